//--- tb/rename_stimulus.txt
# test en allocs freevals tag0 tag1 tag2 tag3 list2free wos0 wos1 wos2 wos3 stall avail
# All fields are hex except the test number and an expected wos of ff is not checked
1 1 0 0 00 10 20 30 0000000000000000 ff ff ff ff 0 ffffffffffffffff
1 1 f 0 00 10 20 30 0000000000000000 00 10 20 30 0 ffffffffffffffff
1 1 0 0 00 10 20 30 0000000000000000 ff ff ff ff 0 fffefffefffefffe
2 1 3 0 00 10 20 30 0000000000000000 01 11 ff ff 0 fffefffefffefffe
2 1 5 0 00 10 20 30 0000000000000000 02 ff 21 ff 0 fffefffefffcfffc
2 1 8 0 00 10 20 30 0000000000000000 ff ff ff 31 0 fffefffcfffcfff8
2 1 f 0 00 10 20 30 0000000000000000 03 12 22 32 0 fffcfffcfffcfff8
3 1 0 2 00 11 20 30 0000000000000000 ff ff ff ff 0 fff8fff8fff8fff0
3 1 3 0 00 10 20 30 0000000000000000 04 13 ff ff 0 fff8fff8fffafff0
3 1 3 0 00 10 20 30 0000000000000000 05 14 ff ff 0 fff8fff8fff2ffe0
3 1 3 0 00 10 20 30 0000000000000000 06 15 ff ff 0 fff8fff8ffe2ffc0
3 1 3 0 00 10 20 30 0000000000000000 07 16 ff ff 0 fff8fff8ffc2ff80
3 1 3 0 00 10 20 30 0000000000000000 08 17 ff ff 0 fff8fff8ff82ff00
3 1 3 0 00 10 20 30 0000000000000000 09 18 ff ff 0 fff8fff8ff02fe00
3 1 3 0 00 10 20 30 0000000000000000 0a 19 ff ff 0 fff8fff8fe02fc00
3 1 3 0 00 10 20 30 0000000000000000 0b 1a ff ff 0 fff8fff8fc02f800
3 1 3 0 00 10 20 30 0000000000000000 0c 1b ff ff 0 fff8fff8f802f000
3 1 3 0 00 10 20 30 0000000000000000 0d 1c ff ff 0 fff8fff8f002e000
3 1 3 0 00 10 20 30 0000000000000000 0e 1d ff ff 0 fff8fff8e002c000
3 1 3 0 00 10 20 30 0000000000000000 0f 1e ff ff 0 fff8fff8c0028000
3 1 2 0 00 10 20 30 0000000000000000 ff 1f ff ff 0 fff8fff880020000
3 1 2 0 00 10 20 30 0000000000000000 ff 11 ff ff 0 fff8fff800020000
4 1 6 6 00 1f 21 30 0000000000000000 ff 1f 21 ff 0 fff8fff800000000
4 1 0 0 00 10 20 30 0000000000000000 ff ff ff ff 0 fff8fff800000000
5 1 0 0 00 10 20 30 0002000504280000 ff ff ff ff 0 fff8fff800000000
5 1 0 0 00 10 20 30 0000000000000000 ff ff ff ff 0 fff8fff800000000
5 1 2 0 00 10 20 30 0000000000000000 ff 15 ff ff 0 fffafff900080000
5 1 0 0 00 10 20 30 0000000000000000 ff ff ff ff 0 fffafffd00080000
5 1 0 0 00 10 20 30 0000000000000000 ff ff ff ff 0 fffafffd04080000
5 1 2 0 00 10 20 30 0000000000000000 ff 13 ff ff 0 fffafffd04080000
6 1 f 0 00 10 20 30 0000000000000000 ff 1a 23 33 1 fffafffd04000000
6 0 c 0 00 10 20 30 0000000000000000 ff ff 24 34 0 fff2fff500000000
6 0 c 0 00 10 20 30 0000000000000001 ff ff 24 34 0 fff2fff500000000
6 1 c 0 00 10 20 30 0000000000000000 ff ff 24 34 0 fff2fff500000000
6 1 0 0 00 10 20 30 0000000000000000 ff ff ff ff 0 ffe2ffe500000000

//--- list.f
design/rename_pkg.sv
design/free_slot_scan.sv
design/free_tag_fifo.sv
design/reg_renamer.sv
tb/tb_reg_renamer.sv

//--- tb/tb_reg_renamer.sv
// Testbench for the physical register renamer
// Replays a stimulus file one line per cycle and checks wos, stall and
// avail against the expected values stored on the same line
`timescale 1ns/1ps
`default_nettype none

module tb_reg_renamer;

	import rename_pkg::*;

	localparam int MAX_LINES     = 200;
	localparam int RESET_TIMEOUT = 20;

	logic                   clk;
	logic                   rst;
	logic                   en;
	logic      [NBANKS-1:0] allocs;
	logic      [NBANKS-1:0] freevals;
	preg_tag_u [NBANKS-1:0] tags2free;
	logic      [PREGS-1:0]  list2free;
	preg_tag_u [NBANKS-1:0] wos;
	logic      [PREGS-1:0]  avail;
	logic                   stall;

	int cur_test;
	int test_count;
	int test_checks;
	int test_errors;
	int total_checks;
	int total_errors;
	int wait_cycles;

	reg_renamer reg_renamer_inst (
		.clk       (clk),
		.rst       (rst),
		.en        (en),
		.allocs    (allocs),
		.freevals  (freevals),
		.tags2free (tags2free),
		.list2free (list2free),
		.wos       (wos),
		.avail     (avail),
		.stall     (stall)
	);

	// 4 ns clock period
	always #2 clk = ~clk;

	// ====================
	// Checks and reports
	// ====================

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		test_checks++;
		total_checks++;
		assert (actual === expected) else begin
			$display("error: test %0d %s expected %0h got %0h", cur_test, name, expected, actual);
			test_errors++;
			total_errors++;
		end
	endtask

	// An expected tag of ff leaves the bank unchecked
	task automatic check_wos(input int bank, input logic [7:0] expected);
		if (expected != 8'hff) begin
			check_value($sformatf("wos[%0d]", bank), expected, wos[bank].flat);
		end
	endtask

	task automatic report_test();
		if (test_errors == 0) begin
			$display("test %0d: ok, %0d checks", cur_test, test_checks);
		end else begin
			$display("test %0d: %0d errors in %0d checks", cur_test, test_errors, test_checks);
		end
		test_count++;
	endtask

	// ====================
	// Stimulus replay
	// ====================

	task automatic run_stimulus();
		int          fd;
		int          n;
		int          line_count;
		string       text_line;
		int          test_v;
		logic [3:0]  en_v;
		logic [3:0]  alloc_v;
		logic [3:0]  free_v;
		logic [7:0]  t_v0, t_v1, t_v2, t_v3;
		logic [63:0] l2f_v;
		logic [7:0]  w_v0, w_v1, w_v2, w_v3;
		logic [3:0]  stall_v;
		logic [63:0] avail_v;
		fd = $fopen("tb/rename_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file tb/rename_stimulus.txt");
			total_errors++;
			return;
		end
		line_count = 0;
		while (!$feof(fd) && line_count < MAX_LINES) begin
			line_count++;
			n = $fgets(text_line, fd);
			// Comment lines and the empty tail of the file carry no cycle
			if (n == 0 || text_line.len() < 2 || text_line.getc(0) == "#") begin
				continue;
			end
			n = $sscanf(text_line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				test_v, en_v, alloc_v, free_v, t_v0, t_v1, t_v2, t_v3, l2f_v,
				w_v0, w_v1, w_v2, w_v3, stall_v, avail_v);
			if (n != 15) begin
				$display("stimulus line %0d could not be parsed", line_count);
				total_errors++;
				continue;
			end
			// A new test number closes the previous test
			if (test_v != cur_test) begin
				if (cur_test > 0) begin
					report_test();
				end
				cur_test    = test_v;
				test_checks = 0;
				test_errors = 0;
			end
			@(posedge clk);
			en           <= en_v[0];
			allocs       <= alloc_v;
			freevals     <= free_v;
			tags2free[0] <= t_v0[TAG_W-1:0];
			tags2free[1] <= t_v1[TAG_W-1:0];
			tags2free[2] <= t_v2[TAG_W-1:0];
			tags2free[3] <= t_v3[TAG_W-1:0];
			list2free    <= l2f_v;
			// Outputs are settled half a period after the inputs change
			@(negedge clk);
			check_wos(0, w_v0);
			check_wos(1, w_v1);
			check_wos(2, w_v2);
			check_wos(3, w_v3);
			check_value("stall", 64'(stall_v[0]), 64'(stall));
			check_value("avail", avail_v, avail);
		end
		if (cur_test > 0) begin
			report_test();
		end
		if (!$feof(fd)) begin
			$display("stimulus file did not end within %0d lines", MAX_LINES);
			total_errors++;
		end
		$fclose(fd);
	endtask

	initial begin
		clk          = 1'b0;
		rst          = 1'b1;
		en           = 1'b0;
		allocs       = '0;
		freevals     = '0;
		tags2free    = '0;
		list2free    = '0;
		cur_test     = 0;
		test_count   = 0;
		test_checks  = 0;
		test_errors  = 0;
		total_checks = 0;
		total_errors = 0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		// Every register should be free once reset has been applied
		wait_cycles = 0;
		while (avail !== '1 && wait_cycles < RESET_TIMEOUT) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (avail !== '1) begin
			$display("avail did not come up all ones within %0d cycles of reset", RESET_TIMEOUT);
			total_errors++;
		end else begin
			run_stimulus();
		end
		$display("tests %0d, checks %0d, errors %0d", test_count, total_checks, total_errors);
		if (total_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- design/reg_renamer.sv
// Physical register renamer
// Four free-list banks hand out up to four destination tags per cycle.
// Frees come from commit, one per bank, or from a flush bitmap that is
// drained one tag per bank per cycle. The available bitmap goes to the ROB
`timescale 1ns/1ps
`default_nettype none

module reg_renamer (
	input  logic                                               clk,
	input  logic                                               rst,
	input  logic                                               en,
	input  logic                  [rename_pkg::NBANKS-1:0]     allocs,
	input  logic                  [rename_pkg::NBANKS-1:0]     freevals,
	input  rename_pkg::preg_tag_u [rename_pkg::NBANKS-1:0]     tags2free,
	input  logic                  [rename_pkg::PREGS-1:0]      list2free,
	output rename_pkg::preg_tag_u [rename_pkg::NBANKS-1:0]     wos,
	output logic                  [rename_pkg::PREGS-1:0]      avail,
	output logic                                               stall
);

	import rename_pkg::*;

	// Registers queued for release by a flush and not yet drained
	logic      [PREGS-1:0]  pending;
	// Pending bits that the bank scans use up this cycle
	logic      [PREGS-1:0]  take_mask;
	preg_tag_u [NBANKS-1:0] scan_tags;
	preg_tag_u [NBANKS-1:0] push_tags;
	logic      [NBANKS-1:0] scan_take;
	logic      [NBANKS-1:0] push;
	logic      [NBANKS-1:0] pop;
	logic      [NBANKS-1:0] bank_stall;

	// ====================
	// Bank free lists
	// ====================

	for (genvar b = 0; b < NBANKS; b++) begin : g_bank
		// Each bank sees only its own 16-bit slice of the pending bitmap
		free_tag_fifo #(
			.BANK_POS (b)
		) fifo_inst (
			.clk       (clk),
			.rst       (rst),
			.en        (en),
			.alloc     (allocs[b]),
			.freeval   (freevals[b]),
			.tag2free  (tags2free[b]),
			.pending   (pending[b*BANK_SIZE +: BANK_SIZE]),
			.wo        (wos[b]),
			.scan_tag  (scan_tags[b]),
			.scan_take (scan_take[b]),
			.push_tag  (push_tags[b]),
			.push      (push[b]),
			.pop       (pop[b]),
			.stall     (bank_stall[b])
		);

		// Only an allocated register can come back to the free list
		assert property (@(posedge clk) disable iff (rst)
			push[b] |-> !avail[push_tags[b].flat]);
	end

	// Any bank that cannot serve its request holds up the whole group
	assign stall = |bank_stall;

	// ====================
	// Available bitmap
	// ====================

	// Banks own disjoint slices of the bitmap, so their updates never overlap.
	// A bank never pops and pushes in the same cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			avail <= '1;
		end else if (en) begin
			for (int b = 0; b < NBANKS; b++) begin
				if (pop[b]) begin
					avail[wos[b].flat] <= 1'b0;
				end
				if (push[b]) begin
					avail[push_tags[b].flat] <= 1'b1;
				end
			end
		end
	end

	// ====================
	// Pending-free bitmap
	// ====================

	always_comb begin
		take_mask = '0;
		for (int b = 0; b < NBANKS; b++) begin
			if (scan_take[b]) begin
				take_mask[scan_tags[b].flat] = 1'b1;
			end
		end
	end

	// New flush bits join the queue and reach the scanners on the next cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
		end else if (en) begin
			pending <= (pending | list2free) & ~take_mask;
		end
	end

	// A flush may only release registers that are currently allocated
	assert property (@(posedge clk) disable iff (rst)
		en |-> (list2free & avail) == '0);

endmodule

`default_nettype wire

//--- design/free_tag_fifo.sv
// Free list of one register bank
// A circular FIFO of 16 tags that serves one allocation per cycle, takes
// back one commit free or one flush-drain free per cycle, and bypasses a
// freed tag straight to the allocation when both happen together
`timescale 1ns/1ps
`default_nettype none

module free_tag_fifo #(
	parameter int unsigned BANK_POS = 0
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             en,
	input  logic                             alloc,
	input  logic                             freeval,
	input  rename_pkg::preg_tag_u            tag2free,
	input  logic [rename_pkg::BANK_SIZE-1:0] pending,
	output rename_pkg::preg_tag_u            wo,
	output rename_pkg::preg_tag_u            scan_tag,
	output logic                             scan_take,
	output rename_pkg::preg_tag_u            push_tag,
	output logic                             push,
	output logic                             pop,
	output logic                             stall
);

	import rename_pkg::*;

	localparam logic [BANK_W-1:0] BANK_ID = bank_of(BANK_POS);

	preg_tag_u         mem [BANK_SIZE];
	logic [SLOT_W-1:0] head;
	logic [SLOT_W-1:0] tail;
	// One bit wider than a pointer so that a full list is told apart from an empty one
	logic [SLOT_W:0]   count;
	logic              empty;
	logic              scan_valid;
	logic [SLOT_W-1:0] scan_slot;

	free_slot_scan scan_inst (
		.pending (pending),
		.valid   (scan_valid),
		.slot    (scan_slot)
	);

	// ====================
	// Action select
	// ====================

	always_comb begin
		scan_tag.f.bank = BANK_ID;
		scan_tag.f.slot = scan_slot;
	end

	assign empty = (count == '0);

	// A commit free outranks the flush drain, and either one outranks the
	// FIFO head when an allocation is made
	assign wo = freeval ? tag2free : (scan_valid ? scan_tag : mem[head]);

	// Nothing can serve the allocation this cycle
	assign stall = alloc & ~freeval & ~scan_valid & empty;

	assign pop       = en & alloc & ~freeval & ~scan_valid & ~empty;
	assign push      = en & ~alloc & (freeval | scan_valid);
	assign push_tag  = freeval ? tag2free : scan_tag;
	// Scan tag is used up by a bypass or a push, but only if no commit free came in
	assign scan_take = en & ~freeval & scan_valid;

	// ====================
	// Pointers and storage
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;
			count <= (SLOT_W + 1)'(BANK_SIZE);
		end else begin
			if (pop) begin
				head  <= head + 1'b1;
				count <= count - 1'b1;
			end
			if (push) begin
				tail  <= tail + 1'b1;
				count <= count + 1'b1;
			end
		end
	end

	// After reset every slot of the bank is free, in ascending order
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < BANK_SIZE; i++) begin
				mem[i].f.bank <= BANK_ID;
				mem[i].f.slot <= SLOT_W'(i);
			end
		end else if (push) begin
			mem[tail] <= push_tag;
		end
	end

	// A push into a full list means a tag was freed twice somewhere upstream
	assert property (@(posedge clk) disable iff (rst)
		push |-> count != (SLOT_W + 1)'(BANK_SIZE));

	// Commit frees must be routed to the bank that owns the tag
	assert property (@(posedge clk) disable iff (rst)
		en && freeval |-> tag2free.f.bank == BANK_ID);

endmodule

`default_nettype wire

//--- design/free_slot_scan.sv
// Flush drain scanner
// Priority encoder over one bank's slice of the pending-free bitmap.
// It returns the lowest slot waiting to be freed
`timescale 1ns/1ps
`default_nettype none

module free_slot_scan (
	input  logic [rename_pkg::BANK_SIZE-1:0] pending,
	output logic                             valid,
	output logic [rename_pkg::SLOT_W-1:0]    slot
);

	import rename_pkg::*;

	// Walk from the top slot down so that the lowest set bit is the last
	// one written and therefore wins
	always_comb begin
		valid = 1'b0;
		slot  = '0;
		for (int i = BANK_SIZE - 1; i >= 0; i--) begin
			if (pending[i]) begin
				valid = 1'b1;
				slot  = SLOT_W'(i);
			end
		end
	end

endmodule

`default_nettype wire

//--- design/rename_pkg.sv
// Rename stage package
// Sizes of the physical register file and its free-list banks, and the
// physical tag that is read either as a flat register number or as a
// bank and slot pair
`default_nettype none

package rename_pkg;

	// ====================
	// Sizes
	// ====================

	localparam int PREGS     = 64;
	localparam int NBANKS    = 4;
	localparam int BANK_SIZE = PREGS / NBANKS;
	localparam int TAG_W     = 6;
	localparam int BANK_W    = 2;
	localparam int SLOT_W    = 4;

	// Bank field sits above the slot field, so the upper bits pick the bank
	typedef struct packed {
		logic [BANK_W-1:0] bank;
		logic [SLOT_W-1:0] slot;
	} preg_fields_t;

	// Same six bits, decoded as a register number or as bank and slot
	typedef union packed {
		logic [TAG_W-1:0] flat;
		preg_fields_t     f;
	} preg_tag_u;

	// Bank number that belongs to a free-list position in the renamer
	function automatic logic [BANK_W-1:0] bank_of(input int unsigned pos);
		return BANK_W'(pos);
	endfunction

endpackage

`default_nettype wire
